// File: src/div_config.svh
// ----------------------------------------------------------
// divider peripheral configuration
// widths, APB register map and queue depth
// ----------------------------------------------------------
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// operand and result width, one word
`define DIV_WIDTH 32

// APB address width
`define DIV_APB_AW 8

// register offsets, word aligned
`define DIV_REG_A      8'h00
`define DIV_REG_B      8'h04
`define DIV_REG_CMD    8'h08
`define DIV_REG_STATUS 8'h0c
`define DIV_REG_QUOT   8'h10
`define DIV_REG_REM    8'h14

// entries per queue
`define DIV_QUEUE_DEPTH 2

`endif

// File: src/div_pkg.sv
// ----------------------------------------------------------
// divider peripheral types
// request, response and APB bus structs
// ----------------------------------------------------------
`include "div_config.svh"

package div_pkg;

  // one division request
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] a;
    logic [`DIV_WIDTH-1:0] b;
    // set for two's complement operands
    logic                  is_signed;
  } div_req_t;

  // one finished result
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] quot;
    logic [`DIV_WIDTH-1:0] rem;
  } div_resp_t;

  // APB master to slave
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`DIV_APB_AW-1:0] paddr;
    logic [`DIV_WIDTH-1:0]  pwdata;
  } apb_req_t;

  // APB slave to master
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_resp_t;

endpackage

// File: src/div_queue.sv
// ----------------------------------------------------------
// small FIFO with valid/ready on both sides
// payload given by a type parameter
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "div_config.svh"

module div_queue #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int DEPTH = `DIV_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic push;
  logic pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // storage, no reset needed
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // pointers wrap at the last entry
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop keeps the count
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: src/div_apb_frontend.sv
// ----------------------------------------------------------
// APB register frontend of the divider
// stages operands, launches requests, serves reads
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "div_config.svh"

module div_apb_frontend import div_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  apb_req_t  apb_req,
  output apb_resp_t apb_resp,
  output div_req_t  req,
  output logic      req_valid,
  input  logic      req_ready,
  input  div_resp_t result,
  input  logic      result_full,
  output logic      result_consume
);

  // staged operands
  logic [`DIV_WIDTH-1:0] a_q;
  logic [`DIV_WIDTH-1:0] b_q;

  // access phase qualifiers
  logic wr_access;
  logic rd_access;

  logic [`DIV_WIDTH-1:0] rd_data;
  logic                  err;

  // second cycle of a transfer, pready is always high
  assign wr_access = apb_req.psel && apb_req.penable && apb_req.pwrite;
  assign rd_access = apb_req.psel && apb_req.penable && !apb_req.pwrite;

  // ----------------------------------------------------------
  // operand staging
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      a_q <= '0;
      b_q <= '0;
    end else if (wr_access) begin
      if (apb_req.paddr == `DIV_REG_A) begin
        a_q <= apb_req.pwdata;
      end
      if (apb_req.paddr == `DIV_REG_B) begin
        b_q <= apb_req.pwdata;
      end
    end
  end

  // ----------------------------------------------------------
  // request launch and result consume
  // ----------------------------------------------------------
  // cmd bit 0 picks signed division
  assign req = '{a: a_q, b: b_q, is_signed: apb_req.pwdata[0]};

  // push offered during the CMD write, queue decides
  assign req_valid = wr_access && (apb_req.paddr == `DIV_REG_CMD);

  // remainder read pops the bank
  assign result_consume = rd_access && (apb_req.paddr == `DIV_REG_REM) && result_full;

  // ----------------------------------------------------------
  // read mux and error decode
  // ----------------------------------------------------------
  always_comb begin
    rd_data = '0;
    err     = 1'b0;
    if (rd_access) begin
      case (apb_req.paddr)
        `DIV_REG_STATUS: rd_data = {{(`DIV_WIDTH-2){1'b0}}, !req_ready, result_full};
        `DIV_REG_QUOT: begin
          if (result_full) begin
            rd_data = result.quot;
          end else begin
            err = 1'b1;
          end
        end
        `DIV_REG_REM: begin
          if (result_full) begin
            rd_data = result.rem;
          end else begin
            err = 1'b1;
          end
        end
        // operands and cmd are write only
        default: err = 1'b1;
      endcase
    end else if (wr_access) begin
      case (apb_req.paddr)
        `DIV_REG_A, `DIV_REG_B: err = 1'b0;
        // request dropped when the queue is full
        `DIV_REG_CMD: err = !req_ready;
        default: err = 1'b1;
      endcase
    end
  end

  assign apb_resp = '{prdata: rd_data, pready: 1'b1, pslverr: err};

endmodule

// File: src/div_iterative.sv
// ----------------------------------------------------------
// iterative restoring divider, one quotient bit per cycle
// signed by magnitudes, divide by zero handled at the output
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "div_config.svh"

module div_iterative import div_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  div_req_t  req,
  input  logic      req_valid,
  output logic      req_ready,
  output div_resp_t resp,
  output logic      resp_valid,
  input  logic      resp_ready
);

  localparam int W = `DIV_WIDTH;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_t;

  state_t     state;
  logic [4:0] count;

  // remainder in the upper half, quotient bits shift in at the bottom
  logic [2*W:0] rq;
  // divisor aligned with the remainder half
  logic [2*W:0] dvs;
  logic         quot_neg;
  logic         rem_neg;
  logic         dbz;

  logic         accept;
  logic [W-1:0] a_mag;
  logic [W-1:0] b_mag;
  logic [2*W:0] shifted;
  logic [2*W:0] diff;
  logic [W-1:0] quot_mag;
  logic [W-1:0] rem_mag;

  assign req_ready  = (state == IDLE);
  assign resp_valid = (state == DONE);
  assign accept     = req_valid && req_ready;

  // ----------------------------------------------------------
  // controller
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= CALC;
            count <= '0;
          end
        end
        // exactly 32 iterations
        CALC: begin
          if (count == 5'd31) begin
            state <= DONE;
          end else begin
            count <= count + 5'd1;
          end
        end
        // hold until the response queue takes it
        DONE: begin
          if (resp_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // datapath
  // ----------------------------------------------------------
  // operand magnitudes, negate only for signed requests
  assign a_mag = (req.is_signed && req.a[W-1]) ? -req.a : req.a;
  assign b_mag = (req.is_signed && req.b[W-1]) ? -req.b : req.b;

  // trial subtraction, bit 2W is the sign of the difference
  assign shifted = rq << 1;
  assign diff    = shifted - dvs;

  always_ff @(posedge clk) begin
    if (accept) begin
      rq       <= {{(W+1){1'b0}}, a_mag};
      dvs      <= {1'b0, b_mag, {W{1'b0}}};
      quot_neg <= req.is_signed && (req.a[W-1] ^ req.b[W-1]);
      // remainder follows the dividend
      rem_neg  <= req.is_signed && req.a[W-1];
      dbz      <= (req.b == '0);
    end else if (state == CALC) begin
      if (diff[2*W]) begin
        // restore, quotient bit 0
        rq <= shifted;
      end else begin
        rq <= {diff[2*W:1], 1'b1};
      end
    end
  end

  // ----------------------------------------------------------
  // result fix-up
  // ----------------------------------------------------------
  assign quot_mag = rq[W-1:0];
  assign rem_mag  = rq[2*W-1:W];

  // with a zero divisor every step keeps, so the remainder magnitude
  // ends up as the dividend magnitude and only the quotient is forced
  assign resp.quot = dbz ? {W{1'b1}} : (quot_neg ? -quot_mag : quot_mag);
  assign resp.rem  = rem_neg ? -rem_mag : rem_mag;

endmodule

// File: src/div_result_bank.sv
// ----------------------------------------------------------
// single entry result holder read by software
// loads while empty, emptied by consume
// ----------------------------------------------------------
`timescale 1ns/1ps

module div_result_bank import div_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  div_resp_t in_data,
  input  logic      in_valid,
  output logic      in_ready,
  output div_resp_t result,
  output logic      full,
  input  logic      consume
);

  div_resp_t data_q;
  logic      full_q;
  logic      load;

  // only one entry, so ready means empty
  assign in_ready = !full_q;
  assign load     = in_valid && in_ready;

  assign result = data_q;
  assign full   = full_q;

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data;
    end
  end

  // load and consume never meet, consume needs a full bank
  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (consume) begin
      full_q <= 1'b0;
    end
  end

endmodule

// File: src/div_apb_top.sv
// ----------------------------------------------------------
// APB divider peripheral top level
// ----------------------------------------------------------
`timescale 1ns/1ps

module div_apb_top import div_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  apb_req_t  apb_req,
  output apb_resp_t apb_resp
);

  // frontend to request queue
  div_req_t  fe_req;
  logic      fe_req_valid;
  logic      fe_req_ready;

  // request queue to divider
  div_req_t  dq_req;
  logic      dq_req_valid;
  logic      dq_req_ready;

  // divider to response queue
  div_resp_t dv_resp;
  logic      dv_resp_valid;
  logic      dv_resp_ready;

  // response queue to bank
  div_resp_t rq_resp;
  logic      rq_resp_valid;
  logic      rq_resp_ready;

  // bank to frontend
  div_resp_t bank_result;
  logic      bank_full;
  logic      bank_consume;

  div_apb_frontend div_apb_frontend_inst (
    .clk            (clk),
    .reset          (reset),
    .apb_req        (apb_req),
    .apb_resp       (apb_resp),
    .req            (fe_req),
    .req_valid      (fe_req_valid),
    .req_ready      (fe_req_ready),
    .result         (bank_result),
    .result_full    (bank_full),
    .result_consume (bank_consume)
  );

  div_queue #(.payload_t(div_req_t)) req_queue_inst (
    .clk       (clk),
    .reset     (reset),
    .in_data   (fe_req),
    .in_valid  (fe_req_valid),
    .in_ready  (fe_req_ready),
    .out_data  (dq_req),
    .out_valid (dq_req_valid),
    .out_ready (dq_req_ready)
  );

  div_iterative div_iterative_inst (
    .clk        (clk),
    .reset      (reset),
    .req        (dq_req),
    .req_valid  (dq_req_valid),
    .req_ready  (dq_req_ready),
    .resp       (dv_resp),
    .resp_valid (dv_resp_valid),
    .resp_ready (dv_resp_ready)
  );

  div_queue #(.payload_t(div_resp_t)) resp_queue_inst (
    .clk       (clk),
    .reset     (reset),
    .in_data   (dv_resp),
    .in_valid  (dv_resp_valid),
    .in_ready  (dv_resp_ready),
    .out_data  (rq_resp),
    .out_valid (rq_resp_valid),
    .out_ready (rq_resp_ready)
  );

  div_result_bank div_result_bank_inst (
    .clk      (clk),
    .reset    (reset),
    .in_data  (rq_resp),
    .in_valid (rq_resp_valid),
    .in_ready (rq_resp_ready),
    .result   (bank_result),
    .full     (bank_full),
    .consume  (bank_consume)
  );

endmodule

// File: bench/div_tb_clock.sv
// ----------------------------------------------------------
// testbench clock source, 100 ns period
// ----------------------------------------------------------
`timescale 1ns/1ps

module div_tb_clock (
  output logic clk
);

  // half of the 100 ns period
  localparam time HALF_PERIOD = 50ns;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

endmodule

// File: bench/div_tb.sv
// ----------------------------------------------------------
// directed testbench of the APB divider peripheral
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "div_config.svh"

module div_tb import div_pkg::*; ();

  localparam int PREADY_LIMIT = 16;
  localparam int POLL_LIMIT   = 200;

  logic        clk;
  logic        reset;
  apb_req_t    apb_req;
  apb_resp_t   apb_resp;

  // requests in issue order for the back-pressure test
  div_req_t pending [$];

  div_tb_clock div_tb_clock_inst (.clk(clk));

  div_apb_top div_apb_top_inst (
    .clk      (clk),
    .reset    (reset),
    .apb_req  (apb_req),
    .apb_resp (apb_resp)
  );

  // ----------------------------------------------------------
  // failure reporting and compare tasks
  // ----------------------------------------------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [`DIV_WIDTH-1:0] exp,
                             input logic [`DIV_WIDTH-1:0] got);
    report_failure($sformatf("FAILED at %0t: %s expected %h got %h", $time, name, exp, got));
  endtask

  task automatic check_resp(input div_resp_t exp, input div_resp_t got, input string tag);
    if (got.quot !== exp.quot) begin
      value_error({tag, " quot"}, exp.quot, got.quot);
    end
    if (got.rem !== exp.rem) begin
      value_error({tag, " rem"}, exp.rem, got.rem);
    end
  endtask

  task automatic check_status(input logic [`DIV_WIDTH-1:0] exp,
                              input logic [`DIV_WIDTH-1:0] got);
    if (got !== exp) begin
      value_error("STATUS", exp, got);
    end
  endtask

  task automatic check_slverr(input logic exp, input logic got, input string tag);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at %0t: pslverr of %s expected %b got %b",
                               $time, tag, exp, got));
    end
  endtask

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  // truncating division, remainder takes the dividend sign
  function automatic div_resp_t ref_divide(input div_req_t r);
    div_resp_t res;
    if (r.b == '0) begin
      res.quot = '1;
      res.rem  = r.a;
    end else if (!r.is_signed) begin
      res.quot = r.a / r.b;
      res.rem  = r.a % r.b;
    end else if (r.a == 32'h8000_0000 && r.b == 32'hffff_ffff) begin
      // overflow wraps to the most negative value
      res.quot = 32'h8000_0000;
      res.rem  = '0;
    end else begin
      res.quot = $signed(r.a) / $signed(r.b);
      res.rem  = $signed(r.a) % $signed(r.b);
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // APB master
  // ----------------------------------------------------------
  // setup cycle, access cycle, response sampled at the falling edge
  task automatic apb_transfer(input logic wr, input logic [`DIV_APB_AW-1:0] addr,
                              input logic [`DIV_WIDTH-1:0] wdata,
                              output logic [`DIV_WIDTH-1:0] rdata, output logic err);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    @(posedge clk);
    #1;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    while (!done) begin
      @(negedge clk);
      if (apb_resp.pready) begin
        rdata = apb_resp.prdata;
        err   = apb_resp.pslverr;
        done  = 1'b1;
      end else begin
        cycles++;
        if (cycles >= PREADY_LIMIT) begin
          report_failure("timeout waiting for pready");
        end
        @(posedge clk);
        #1;
      end
    end
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [`DIV_APB_AW-1:0] addr,
                           input logic [`DIV_WIDTH-1:0] data, output logic err);
    logic [`DIV_WIDTH-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [`DIV_APB_AW-1:0] addr,
                          output logic [`DIV_WIDTH-1:0] data, output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  // poll STATUS until the given bit reaches the wanted value
  task automatic wait_status_bit(input int idx, input logic value, input string what);
    logic [`DIV_WIDTH-1:0] status;
    logic                  err;
    int                    polls;
    polls = 0;
    apb_read(`DIV_REG_STATUS, status, err);
    check_slverr(1'b0, err, "STATUS read");
    while (status[idx] !== value) begin
      polls++;
      if (polls == POLL_LIMIT) begin
        report_failure($sformatf("timeout waiting for %s", what));
      end
      apb_read(`DIV_REG_STATUS, status, err);
      check_slverr(1'b0, err, "STATUS read");
    end
  endtask

  task automatic wait_result();
    wait_status_bit(0, 1'b1, "a result in the bank");
  endtask

  // ----------------------------------------------------------
  // request helpers
  // ----------------------------------------------------------
  task automatic issue_request(input div_req_t r);
    logic err;
    apb_write(`DIV_REG_A, r.a, err);
    check_slverr(1'b0, err, "A write");
    apb_write(`DIV_REG_B, r.b, err);
    check_slverr(1'b0, err, "B write");
    apb_write(`DIV_REG_CMD, {{(`DIV_WIDTH-1){1'b0}}, r.is_signed}, err);
    check_slverr(1'b0, err, "CMD write");
  endtask

  // quotient first, the remainder read frees the bank
  task automatic read_result(input div_req_t r, input string tag);
    div_resp_t got;
    logic      err;
    wait_result();
    apb_read(`DIV_REG_QUOT, got.quot, err);
    check_slverr(1'b0, err, "QUOT read");
    apb_read(`DIV_REG_REM, got.rem, err);
    check_slverr(1'b0, err, "REM read");
    check_resp(ref_divide(r), got, tag);
  endtask

  task automatic run_division(input div_req_t r, input string tag);
    issue_request(r);
    read_result(r, tag);
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic test_errors();
    logic [`DIV_WIDTH-1:0] data;
    logic                  err;
    div_req_t              r;
    apb_read(`DIV_REG_STATUS, data, err);
    check_slverr(1'b0, err, "STATUS read");
    check_status('0, data);
    // empty bank
    apb_read(`DIV_REG_QUOT, data, err);
    check_slverr(1'b1, err, "QUOT read of empty bank");
    if (data !== '0) value_error("prdata of empty QUOT", '0, data);
    apb_read(`DIV_REG_REM, data, err);
    check_slverr(1'b1, err, "REM read of empty bank");
    if (data !== '0) value_error("prdata of empty REM", '0, data);
    // unknown offset, both directions
    apb_read(8'h18, data, err);
    check_slverr(1'b1, err, "read of unknown address");
    apb_write(8'h18, 32'h1234_5678, err);
    check_slverr(1'b1, err, "write of unknown address");
    // REM read clears the full flag
    r = '{a: 32'd100, b: 32'd7, is_signed: 1'b0};
    issue_request(r);
    wait_result();
    apb_read(`DIV_REG_STATUS, data, err);
    check_status(32'h1, data);
    apb_read(`DIV_REG_REM, data, err);
    check_slverr(1'b0, err, "REM read of full bank");
    if (data !== 32'd2) value_error("REM", 32'd2, data);
    apb_read(`DIV_REG_STATUS, data, err);
    check_status('0, data);
  endtask

  task automatic test_unsigned();
    div_req_t r;
    for (int i = 0; i < 20; i++) begin
      // shifted divisor gives a spread of quotient sizes
      r = '{a: $urandom, b: $urandom >> ($urandom % 32), is_signed: 1'b0};
      run_division(r, $sformatf("unsigned %0d", i));
    end
  endtask

  task automatic test_signed();
    div_req_t              r;
    logic [`DIV_WIDTH-1:0] a_mag;
    logic [`DIV_WIDTH-1:0] b_mag;
    for (int i = 0; i < 4; i++) begin
      a_mag = $urandom & 32'h7fff_ffff;
      b_mag = ($urandom & 32'h0000_ffff) + 1;
      r.a   = i[0] ? -a_mag : a_mag;
      r.b   = i[1] ? -b_mag : b_mag;
      r.is_signed = 1'b1;
      run_division(r, $sformatf("signed combination %0d", i));
    end
    r = '{a: 32'h8000_0000, b: 32'hffff_ffff, is_signed: 1'b1};
    run_division(r, "signed overflow");
  endtask

  task automatic test_div_zero();
    run_division('{a: 32'hdead_beef, b: '0, is_signed: 1'b0}, "unsigned by zero");
    run_division('{a: 32'hdead_beef, b: '0, is_signed: 1'b1}, "signed negative by zero");
    run_division('{a: 32'h0001_2345, b: '0, is_signed: 1'b1}, "signed positive by zero");
  endtask

  // six in flight fill every stage, the seventh is refused
  task automatic test_backpressure();
    div_req_t              r;
    logic [`DIV_WIDTH-1:0] status;
    logic                  err;
    pending.delete();
    for (int i = 0; i < 6; i++) begin
      r = '{a: $urandom, b: ($urandom & 32'hff) + 1, is_signed: i[0]};
      // the divider drains slower than requests arrive
      wait_status_bit(1, 1'b0, "room in the request queue");
      issue_request(r);
      pending.push_back(r);
    end
    wait_status_bit(1, 1'b1, "a full request queue");
    apb_read(`DIV_REG_STATUS, status, err);
    check_status(32'h3, status);
    apb_write(`DIV_REG_CMD, '0, err);
    check_slverr(1'b1, err, "CMD write to full queue");
    for (int i = 0; i < 6; i++) begin
      read_result(pending.pop_front(), $sformatf("ordered result %0d", i));
    end
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(32'h83e7d95c));
    reset    = 1'b1;
    apb_req  = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    test_errors();
    test_unsigned();
    test_signed();
    test_div_zero();
    test_backpressure();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: compile.f
+incdir+src
src/div_pkg.sv
src/div_queue.sv
src/div_apb_frontend.sv
src/div_iterative.sv
src/div_result_bank.sv
src/div_apb_top.sv
bench/div_tb_clock.sv
bench/div_tb.sv

// File: run.sh
#!/bin/sh
# build the divider testbench with Verilator, run it, then search the log
verilator --binary --timing -Wno-fatal -f compile.f --top-module div_tb \
  -o div_tb_sim > build.log 2>&1 \
  && ./obj_dir/div_tb_sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "^Finished with no errors$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; cat sim.log; exit 1; }
